// ==== design/axi_xbar_pkg.sv ====
// Write crossbar package with widths, the address map, channel structs and response codes
`default_nettype none

package axi_xbar_pkg;

    // Port counts and field widths
    localparam int S_COUNT = 2;
    localparam int M_COUNT = 2;
    localparam int SEL_W = 1;
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;
    localparam int S_ID_W = 4;
    localparam int M_ID_W = S_ID_W + 1;
    localparam int LEN_W = 8;

    // One 4 KiB window per output, window number sits above WIN_W
    localparam int WIN_W = 12;
    localparam int WIN_NUM_W = ADDR_W - WIN_W;

    localparam logic [1:0] RESP_OKAY = 2'd0;
    localparam logic [1:0] RESP_DECERR = 2'd3;

    typedef struct packed {
        logic [S_ID_W-1:0] id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
    } s_aw_t;

    typedef struct packed {
        logic [M_ID_W-1:0] id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
    } m_aw_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } w_beat_t;

    typedef struct packed {
        logic [S_ID_W-1:0] id;
        logic [1:0]        resp;
    } s_b_t;

    typedef struct packed {
        logic [M_ID_W-1:0] id;
        logic [1:0]        resp;
    } m_b_t;

    // Windows past the last output have no target
    function automatic logic addr_decerr(input logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1:WIN_W] >= WIN_NUM_W'(M_COUNT);
    endfunction

    function automatic logic [SEL_W-1:0] addr_sel(input logic [ADDR_W-1:0] addr);
        return addr[WIN_W +: SEL_W];
    endfunction

endpackage

`default_nettype wire

// ==== design/rr_arbiter.sv ====
// Round-robin arbiter that holds its grant until the winner acknowledges
`default_nettype none

module rr_arbiter #(
    parameter int PORTS = 2,
    localparam int IDX_W = (PORTS > 1) ? $clog2(PORTS) : 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [PORTS-1:0] req,
    input  logic [PORTS-1:0] ack,
    output logic [PORTS-1:0] grant,
    output logic             grant_valid,
    output logic [IDX_W-1:0] grant_index
);

    // Last winner, also the index of the grant while it is held
    logic [IDX_W-1:0] last_q;
    logic             held_q;
    logic [IDX_W-1:0] pick;
    logic             pick_valid;

    // Walk backwards from the far side so the nearest requester after last_q wins
    always_comb begin
        int cand;
        pick = last_q;
        pick_valid = 1'b0;
        for (int i = PORTS; i >= 1; i--) begin
            cand = (int'(last_q) + i) % PORTS;
            if (req[cand]) begin
                pick = IDX_W'(cand);
                pick_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            held_q <= 1'b0;
            last_q <= IDX_W'(PORTS - 1);
        end else if (held_q) begin
            if (|(ack & grant)) begin
                held_q <= 1'b0;
            end
        end else if (pick_valid) begin
            held_q <= 1'b1;
            last_q <= pick;
        end
    end

    always_comb begin
        grant = '0;
        grant[last_q] = held_q;
    end

    assign grant_valid = held_q;
    assign grant_index = last_q;

endmodule

`default_nettype wire

// ==== design/xbar_input_port.sv ====
// Crossbar input port with address decode, W steering, DECERR responder and B merge
`default_nettype none

module xbar_input_port #(
    parameter int PORT_INDEX = 0
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  axi_xbar_pkg::s_aw_t                     s_aw,
    input  logic                                    s_aw_valid,
    output logic                                    s_aw_ready,
    input  axi_xbar_pkg::w_beat_t                   s_w,
    input  logic                                    s_w_valid,
    output logic                                    s_w_ready,
    output axi_xbar_pkg::s_b_t                      s_b,
    output logic                                    s_b_valid,
    input  logic                                    s_b_ready,
    output logic [axi_xbar_pkg::M_COUNT-1:0]        aw_req,
    input  logic [axi_xbar_pkg::M_COUNT-1:0]        aw_accept,
    output logic [axi_xbar_pkg::M_COUNT-1:0]        w_valid_out,
    input  logic [axi_xbar_pkg::M_COUNT-1:0]        w_ready_in,
    input  axi_xbar_pkg::m_b_t [axi_xbar_pkg::M_COUNT-1:0] b_in,
    input  logic [axi_xbar_pkg::M_COUNT-1:0]        b_valid_in,
    output logic [axi_xbar_pkg::M_COUNT-1:0]        b_ready_out
);
    import axi_xbar_pkg::*;

    localparam int SRC_W = M_ID_W - S_ID_W;
    // Returning outputs plus the local DECERR slot on top
    localparam int B_PORTS = M_COUNT + 1;
    localparam int B_IDX_W = $clog2(B_PORTS);

    logic             aw_dec;
    logic [SEL_W-1:0] aw_sel;
    logic             aw_fire;
    logic             w_last_fire;

    // Open burst state
    logic             w_open_q;
    logic [SEL_W-1:0] w_sel_q;
    logic             w_drop_q;

    // Pending DECERR response, stored with the full downstream ID
    logic             dec_valid_q;
    m_b_t             dec_b_q;

    m_b_t [B_PORTS-1:0] b_cand;
    logic [B_PORTS-1:0] b_cand_valid;
    logic [B_PORTS-1:0] b_grant;
    logic [B_PORTS-1:0] b_ack;
    logic               b_grant_valid;
    logic [B_IDX_W-1:0] b_index;
    m_b_t               b_sel;

    assign aw_dec = addr_decerr(s_aw.addr);
    assign aw_sel = addr_sel(s_aw.addr);

    // No new command until the previous burst has sent its last beat
    always_comb begin
        aw_req = '0;
        aw_req[aw_sel] = s_aw_valid && !aw_dec && !w_open_q;
    end

    assign s_aw_ready = !w_open_q && (aw_dec ? !dec_valid_q : aw_accept[aw_sel]);
    assign aw_fire = s_aw_valid && s_aw_ready;

    // W goes to the one output of the open burst, dropped bursts sink here
    always_comb begin
        w_valid_out = '0;
        w_valid_out[w_sel_q] = s_w_valid && w_open_q && !w_drop_q;
    end

    assign s_w_ready = w_open_q && (w_drop_q || w_ready_in[w_sel_q]);
    assign w_last_fire = s_w_valid && s_w_ready && s_w.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            w_open_q <= 1'b0;
        end else if (aw_fire) begin
            w_open_q <= 1'b1;
        end else if (w_last_fire) begin
            w_open_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            w_sel_q <= aw_sel;
            w_drop_q <= aw_dec;
        end
    end

    // DECERR becomes pending once the dropped burst's data is gone
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid_q <= 1'b0;
        end else if (w_last_fire && w_drop_q) begin
            dec_valid_q <= 1'b1;
        end else if (b_ack[M_COUNT]) begin
            dec_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire && aw_dec) begin
            dec_b_q.id <= {SRC_W'(PORT_INDEX), s_aw.id};
            dec_b_q.resp <= RESP_DECERR;
        end
    end

    assign b_cand = {dec_b_q, b_in};
    assign b_cand_valid = {dec_valid_q, b_valid_in};

    rr_arbiter #(
        .PORTS(B_PORTS)
    ) u_b_arb (
        .clk(clk),
        .rst(rst),
        .req(b_cand_valid),
        .ack(b_ack),
        .grant(b_grant),
        .grant_valid(b_grant_valid),
        .grant_index(b_index)
    );

    // Strip the input prefix on the way back up
    assign b_sel = b_cand[b_index];
    assign s_b.id = b_sel.id[S_ID_W-1:0];
    assign s_b.resp = b_sel.resp;
    assign s_b_valid = b_grant_valid && b_cand_valid[b_index];

    assign b_ack = b_grant & {B_PORTS{s_b_valid && s_b_ready}};
    assign b_ready_out = b_grant[M_COUNT-1:0] & {M_COUNT{s_b_ready}};

endmodule

`default_nettype wire

// ==== design/xbar_output_port.sv ====
// Crossbar output port with AW arbitration, ID extension, W mux, issue limit and B steering
`default_nettype none

module xbar_output_port #(
    parameter int M_ISSUE = 4
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic [axi_xbar_pkg::S_COUNT-1:0]           aw_req_in,
    input  axi_xbar_pkg::s_aw_t [axi_xbar_pkg::S_COUNT-1:0] aw_in,
    output logic [axi_xbar_pkg::S_COUNT-1:0]           aw_accept,
    input  axi_xbar_pkg::w_beat_t [axi_xbar_pkg::S_COUNT-1:0] w_in,
    input  logic [axi_xbar_pkg::S_COUNT-1:0]           w_valid_in,
    output logic [axi_xbar_pkg::S_COUNT-1:0]           w_ready_out,
    output axi_xbar_pkg::m_aw_t                        m_aw,
    output logic                                       m_aw_valid,
    input  logic                                       m_aw_ready,
    output axi_xbar_pkg::w_beat_t                      m_w,
    output logic                                       m_w_valid,
    input  logic                                       m_w_ready,
    input  axi_xbar_pkg::m_b_t                         m_b,
    input  logic                                       m_b_valid,
    output logic                                       m_b_ready,
    output logic [axi_xbar_pkg::S_COUNT-1:0]           b_valid_out,
    input  logic [axi_xbar_pkg::S_COUNT-1:0]           b_ready_in
);
    import axi_xbar_pkg::*;

    localparam int SRC_W = M_ID_W - S_ID_W;
    localparam int CNT_W = $clog2(M_ISSUE + 1);

    logic [S_COUNT-1:0] arb_req;
    logic [S_COUNT-1:0] arb_grant;
    logic               arb_valid;
    logic [SRC_W-1:0]   arb_index;

    logic [CNT_W-1:0]   issue_cnt_q;
    logic               issue_full;
    logic               aw_fire;
    logic               b_fire;

    // W source state
    logic               w_busy_q;
    logic               w_busy_next;
    logic [SRC_W-1:0]   w_src_q;
    logic               w_latch;
    logic               w_done;

    logic [SRC_W-1:0]   b_dst;

    assign issue_full = issue_cnt_q == CNT_W'(M_ISSUE);

    // A new grant only when W will be free, keeps W in AW order
    assign arb_req = (issue_full || w_busy_next) ? '0 : aw_req_in;

    rr_arbiter #(
        .PORTS(S_COUNT)
    ) u_aw_arb (
        .clk(clk),
        .rst(rst),
        .req(arb_req),
        .ack(aw_accept),
        .grant(arb_grant),
        .grant_valid(arb_valid),
        .grant_index(arb_index)
    );

    // Input index goes on top of the upstream ID
    assign m_aw.id = {arb_index, aw_in[arb_index].id};
    assign m_aw.addr = aw_in[arb_index].addr;
    assign m_aw.len = aw_in[arb_index].len;
    assign m_aw_valid = arb_valid && aw_req_in[arb_index];

    assign aw_fire = m_aw_valid && m_aw_ready;
    assign aw_accept = arb_grant & {S_COUNT{aw_fire}};

    // Outstanding writes, AW handshake to B handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_cnt_q <= '0;
        end else if (aw_fire && !b_fire) begin
            issue_cnt_q <= issue_cnt_q + 1'b1;
        end else if (!aw_fire && b_fire) begin
            issue_cnt_q <= issue_cnt_q - 1'b1;
        end
    end

    assign w_latch = arb_valid && !w_busy_q;
    assign w_done = m_w_valid && m_w_ready && m_w.last;
    assign w_busy_next = w_latch || (w_busy_q && !w_done);

    always_ff @(posedge clk) begin
        if (rst) begin
            w_busy_q <= 1'b0;
        end else begin
            w_busy_q <= w_busy_next;
        end
    end

    always_ff @(posedge clk) begin
        if (w_latch) begin
            w_src_q <= arb_index;
        end
    end

    assign m_w = w_in[w_src_q];
    assign m_w_valid = w_busy_q && w_valid_in[w_src_q];

    always_comb begin
        w_ready_out = '0;
        w_ready_out[w_src_q] = w_busy_q && m_w_ready;
    end

    // B goes back to the input named by the ID prefix
    assign b_dst = m_b.id[M_ID_W-1 -: SRC_W];

    always_comb begin
        b_valid_out = '0;
        b_valid_out[b_dst] = m_b_valid;
    end

    assign m_b_ready = b_ready_in[b_dst];
    assign b_fire = m_b_valid && m_b_ready;

endmodule

`default_nettype wire

// ==== design/axi_xbar_wr.sv ====
// Write-only AXI4 crossbar top joining the input ports to the output ports
`default_nettype none

module axi_xbar_wr #(
    parameter int M_ISSUE = 4
) (
    input  logic                                              clk,
    input  logic                                              rst,
    input  axi_xbar_pkg::s_aw_t   [axi_xbar_pkg::S_COUNT-1:0] s_aw,
    input  logic                  [axi_xbar_pkg::S_COUNT-1:0] s_aw_valid,
    output logic                  [axi_xbar_pkg::S_COUNT-1:0] s_aw_ready,
    input  axi_xbar_pkg::w_beat_t [axi_xbar_pkg::S_COUNT-1:0] s_w,
    input  logic                  [axi_xbar_pkg::S_COUNT-1:0] s_w_valid,
    output logic                  [axi_xbar_pkg::S_COUNT-1:0] s_w_ready,
    output axi_xbar_pkg::s_b_t    [axi_xbar_pkg::S_COUNT-1:0] s_b,
    output logic                  [axi_xbar_pkg::S_COUNT-1:0] s_b_valid,
    input  logic                  [axi_xbar_pkg::S_COUNT-1:0] s_b_ready,
    output axi_xbar_pkg::m_aw_t   [axi_xbar_pkg::M_COUNT-1:0] m_aw,
    output logic                  [axi_xbar_pkg::M_COUNT-1:0] m_aw_valid,
    input  logic                  [axi_xbar_pkg::M_COUNT-1:0] m_aw_ready,
    output axi_xbar_pkg::w_beat_t [axi_xbar_pkg::M_COUNT-1:0] m_w,
    output logic                  [axi_xbar_pkg::M_COUNT-1:0] m_w_valid,
    input  logic                  [axi_xbar_pkg::M_COUNT-1:0] m_w_ready,
    input  axi_xbar_pkg::m_b_t    [axi_xbar_pkg::M_COUNT-1:0] m_b,
    input  logic                  [axi_xbar_pkg::M_COUNT-1:0] m_b_valid,
    output logic                  [axi_xbar_pkg::M_COUNT-1:0] m_b_ready
);
    import axi_xbar_pkg::*;

    // Seen from each input, one bit per output
    logic [M_COUNT-1:0] in_aw_req    [S_COUNT];
    logic [M_COUNT-1:0] in_aw_accept [S_COUNT];
    logic [M_COUNT-1:0] in_w_valid   [S_COUNT];
    logic [M_COUNT-1:0] in_w_ready   [S_COUNT];
    logic [M_COUNT-1:0] in_b_valid   [S_COUNT];
    logic [M_COUNT-1:0] in_b_ready   [S_COUNT];

    // Seen from each output, one bit per input
    logic [S_COUNT-1:0] out_aw_req    [M_COUNT];
    logic [S_COUNT-1:0] out_aw_accept [M_COUNT];
    logic [S_COUNT-1:0] out_w_valid   [M_COUNT];
    logic [S_COUNT-1:0] out_w_ready   [M_COUNT];
    logic [S_COUNT-1:0] out_b_valid   [M_COUNT];
    logic [S_COUNT-1:0] out_b_ready   [M_COUNT];

    for (genvar i = 0; i < S_COUNT; i++) begin : g_tr_in
        for (genvar o = 0; o < M_COUNT; o++) begin : g_tr_out
            assign out_aw_req[o][i] = in_aw_req[i][o];
            assign in_aw_accept[i][o] = out_aw_accept[o][i];
            assign out_w_valid[o][i] = in_w_valid[i][o];
            assign in_w_ready[i][o] = out_w_ready[o][i];
            assign in_b_valid[i][o] = out_b_valid[o][i];
            assign out_b_ready[o][i] = in_b_ready[i][o];
        end
    end

    for (genvar i = 0; i < S_COUNT; i++) begin : g_in
        xbar_input_port #(
            .PORT_INDEX(i)
        ) u_in (
            .clk(clk),
            .rst(rst),
            .s_aw(s_aw[i]),
            .s_aw_valid(s_aw_valid[i]),
            .s_aw_ready(s_aw_ready[i]),
            .s_w(s_w[i]),
            .s_w_valid(s_w_valid[i]),
            .s_w_ready(s_w_ready[i]),
            .s_b(s_b[i]),
            .s_b_valid(s_b_valid[i]),
            .s_b_ready(s_b_ready[i]),
            .aw_req(in_aw_req[i]),
            .aw_accept(in_aw_accept[i]),
            .w_valid_out(in_w_valid[i]),
            .w_ready_in(in_w_ready[i]),
            .b_in(m_b),
            .b_valid_in(in_b_valid[i]),
            .b_ready_out(in_b_ready[i])
        );
    end

    for (genvar o = 0; o < M_COUNT; o++) begin : g_out
        xbar_output_port #(
            .M_ISSUE(M_ISSUE)
        ) u_out (
            .clk(clk),
            .rst(rst),
            .aw_req_in(out_aw_req[o]),
            .aw_in(s_aw),
            .aw_accept(out_aw_accept[o]),
            .w_in(s_w),
            .w_valid_in(out_w_valid[o]),
            .w_ready_out(out_w_ready[o]),
            .m_aw(m_aw[o]),
            .m_aw_valid(m_aw_valid[o]),
            .m_aw_ready(m_aw_ready[o]),
            .m_w(m_w[o]),
            .m_w_valid(m_w_valid[o]),
            .m_w_ready(m_w_ready[o]),
            .m_b(m_b[o]),
            .m_b_valid(m_b_valid[o]),
            .m_b_ready(m_b_ready[o]),
            .b_valid_out(out_b_valid[o]),
            .b_ready_in(out_b_ready[o])
        );
    end

endmodule

`default_nettype wire

// ==== sim/axi_xbar_wr_checks.svh ====
// Write crossbar testbench helpers for checks, random data and expected routing
`ifndef AXI_XBAR_WR_CHECKS_SVH
`define AXI_XBAR_WR_CHECKS_SVH

logic [31:0] rng_state = 32'd99550;

task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
endtask

// Compares one value against its expected value
task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
        stop_run($sformatf("FAILED %s expected %0h actual %0h", name, exp, act));
    end
endtask

// 32-bit xorshift
function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// Window number of an address, windows from M_COUNT upwards have no output
function automatic int window_of(input logic [ADDR_W-1:0] addr);
    return int'(addr >> WIN_W);
endfunction

`endif

// ==== sim/axi_xbar_wr_tb.sv ====
// Write crossbar testbench with stimulus table, downstream responders and scoreboard
`default_nettype none

module axi_xbar_wr_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import axi_xbar_pkg::*;

    `include "axi_xbar_wr_checks.svh"

    localparam int ISSUE = 2;
    localparam int N_ROWS = 10;
    // Two extra phases after the table count as rows
    localparam int WATCH_CYCLES = (N_ROWS + 2) * 200;

    typedef struct packed {
        logic              port;
        logic [ADDR_W-1:0] addr;
        logic [S_ID_W-1:0] id;
        logic [3:0]        len;
        logic              conc;
    } row_t;

    logic clk = 1'b0;
    logic rst;
    s_aw_t   [S_COUNT-1:0] s_aw;
    logic    [S_COUNT-1:0] s_aw_valid;
    logic    [S_COUNT-1:0] s_aw_ready;
    w_beat_t [S_COUNT-1:0] s_w;
    logic    [S_COUNT-1:0] s_w_valid;
    logic    [S_COUNT-1:0] s_w_ready;
    s_b_t    [S_COUNT-1:0] s_b;
    logic    [S_COUNT-1:0] s_b_valid;
    logic    [S_COUNT-1:0] s_b_ready;
    m_aw_t   [M_COUNT-1:0] m_aw;
    logic    [M_COUNT-1:0] m_aw_valid;
    logic    [M_COUNT-1:0] m_aw_ready;
    w_beat_t [M_COUNT-1:0] m_w;
    logic    [M_COUNT-1:0] m_w_valid;
    logic    [M_COUNT-1:0] m_w_ready;
    m_b_t    [M_COUNT-1:0] m_b;
    logic    [M_COUNT-1:0] m_b_valid;
    logic    [M_COUNT-1:0] m_b_ready;

    // Scoreboard keyed by output and downstream ID
    bit                exp_pending [M_COUNT][32];
    logic [ADDR_W-1:0] exp_addr [M_COUNT][32];
    int                exp_len [M_COUNT][32];
    logic [DATA_W-1:0] exp_data [M_COUNT][32][16];
    int                exp_b_cnt [S_COUNT][16];
    logic [1:0]        exp_b_resp [S_COUNT][16];
    int                b_pending = 0;
    int                outst [M_COUNT];
    int                aw_cnt [M_COUNT];
    int                beat_idx [M_COUNT];
    int                aw_order [M_COUNT][$];
    int                b_q [M_COUNT][$];
    bit                b_hold [M_COUNT];
    bit                sb_hold [S_COUNT];
    row_t              rows [N_ROWS];
    int                i;
    int                base;

    always #4 clk = ~clk;

    axi_xbar_wr #(
        .M_ISSUE(ISSUE)
    ) DUT (
        .clk(clk), .rst(rst),
        .s_aw(s_aw), .s_aw_valid(s_aw_valid), .s_aw_ready(s_aw_ready),
        .s_w(s_w), .s_w_valid(s_w_valid), .s_w_ready(s_w_ready),
        .s_b(s_b), .s_b_valid(s_b_valid), .s_b_ready(s_b_ready),
        .m_aw(m_aw), .m_aw_valid(m_aw_valid), .m_aw_ready(m_aw_ready),
        .m_w(m_w), .m_w_valid(m_w_valid), .m_w_ready(m_w_ready),
        .m_b(m_b), .m_b_valid(m_b_valid), .m_b_ready(m_b_ready)
    );

    task automatic run_write(input int p, input logic [ADDR_W-1:0] addr,
                             input logic [S_ID_W-1:0] id, input int len);
        int o;
        int mid;
        bit dec;
        logic [DATA_W-1:0] data [16];
        o = window_of(addr);
        dec = o >= M_COUNT;
        mid = p * 16 + int'(id);
        for (int b = 0; b <= len; b++) begin
            data[b] = next_rand();
        end
        if (!dec) begin
            exp_pending[o][mid] = 1'b1;
            exp_addr[o][mid] = addr;
            exp_len[o][mid] = len;
            for (int b = 0; b <= len; b++) begin
                exp_data[o][mid][b] = data[b];
            end
            exp_b_cnt[p][id] = exp_b_cnt[p][id] + 1;
        end
        exp_b_resp[p][id] = dec ? RESP_DECERR : RESP_OKAY;
        b_pending = b_pending + 1;
        @(negedge clk);
        s_aw[p] = '{id: id, addr: addr, len: LEN_W'(len)};
        s_aw_valid[p] = 1'b1;
        #3;
        while (!s_aw_ready[p]) begin
            @(negedge clk);
            #3;
        end
        @(negedge clk);
        s_aw_valid[p] = 1'b0;
        for (int b = 0; b <= len; b++) begin
            s_w[p] = '{data: data[b], strb: 4'hf, last: b == len};
            s_w_valid[p] = 1'b1;
            #3;
            while (!s_w_ready[p]) begin
                @(negedge clk);
                #3;
            end
            @(negedge clk);
        end
        s_w_valid[p] = 1'b0;
        // A DECERR is only due once every beat of the burst is accepted
        if (dec) begin
            exp_b_cnt[p][id] = exp_b_cnt[p][id] + 1;
        end
    endtask

    // Downstream model, accepts AW and W and answers each burst with OKAY
    task automatic serve_output(input int o);
        int mid;
        bit b_done;
        b_done = 1'b0;
        forever begin
            @(negedge clk);
            if (b_done) begin
                m_b_valid[o] = 1'b0;
                b_done = 1'b0;
            end
            if (!rst && !m_b_valid[o] && b_q[o].size() > 0 && !b_hold[o]) begin
                m_b[o] = '{id: M_ID_W'(b_q[o][0]), resp: RESP_OKAY};
                m_b_valid[o] = 1'b1;
            end
            #3;
            if (!rst && m_aw_valid[o] && m_aw_ready[o]) begin
                mid = int'(m_aw[o].id);
                if (!exp_pending[o][mid]) begin
                    stop_run($sformatf("Unexpected AW with ID %0h on output %0d", mid, o));
                end
                exp_pending[o][mid] = 1'b0;
                check_val($sformatf("out%0d aw addr", o), 64'(exp_addr[o][mid]),
                          64'(m_aw[o].addr));
                check_val($sformatf("out%0d aw len", o), 64'(exp_len[o][mid]),
                          64'(m_aw[o].len));
                aw_order[o].push_back(mid);
                aw_cnt[o] = aw_cnt[o] + 1;
                outst[o] = outst[o] + 1;
                check_val($sformatf("out%0d issue limit", o), 64'(1), 64'(outst[o] <= ISSUE));
            end
            if (!rst && m_w_valid[o] && m_w_ready[o]) begin
                if (aw_order[o].size() == 0) begin
                    stop_run($sformatf("W beat without an open burst on output %0d", o));
                end
                mid = aw_order[o][0];
                check_val($sformatf("out%0d w data id %0h", o, mid),
                          64'(exp_data[o][mid][beat_idx[o]]), 64'(m_w[o].data));
                check_val($sformatf("out%0d w strb", o), 64'(4'hf), 64'(m_w[o].strb));
                check_val($sformatf("out%0d w last", o), 64'(beat_idx[o] == exp_len[o][mid]),
                          64'(m_w[o].last));
                beat_idx[o] = beat_idx[o] + 1;
                if (m_w[o].last) begin
                    void'(aw_order[o].pop_front());
                    b_q[o].push_back(mid);
                    beat_idx[o] = 0;
                end
            end
            if (!rst && m_b_valid[o] && m_b_ready[o]) begin
                void'(b_q[o].pop_front());
                outst[o] = outst[o] - 1;
                b_done = 1'b1;
            end
        end
    endtask

    task automatic collect_b(input int p);
        int id;
        forever begin
            @(negedge clk);
            s_b_ready[p] = !sb_hold[p];
            #3;
            if (!rst && s_b_valid[p] && s_b_ready[p]) begin
                id = int'(s_b[p].id);
                if (exp_b_cnt[p][id] == 0) begin
                    stop_run($sformatf("Unexpected response with ID %0h on input %0d", id, p));
                end
                check_val($sformatf("in%0d b resp id %0h", p, id), 64'(exp_b_resp[p][id]),
                          64'(s_b[p].resp));
                exp_b_cnt[p][id] = exp_b_cnt[p][id] - 1;
                b_pending = b_pending - 1;
            end
        end
    endtask

    task automatic check_idle(input string name);
        check_val(name, 64'(0), 64'({m_aw_valid, m_w_valid, s_b_valid}));
    endtask

    task automatic wait_drain();
        while (b_pending != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic run_row(input int r);
        run_write(int'(rows[r].port), rows[r].addr, rows[r].id, int'(rows[r].len));
    endtask

    initial begin
        #(WATCH_CYCLES * 8);
        stop_run("Timeout: the run did not finish in time");
    end

    initial begin
        rst = 1'b1;
        s_aw = '0;
        s_aw_valid = '0;
        s_w = '0;
        s_w_valid = '0;
        s_b_ready = '1;
        m_aw_ready = '1;
        m_w_ready = '1;
        m_b = '0;
        m_b_valid = '0;
        // Port, address, ID, length, issued together with the next row
        rows[0] = '{1'b0, 16'h0010, 4'd1, 4'd0, 1'b0};
        rows[1] = '{1'b0, 16'h1020, 4'd2, 4'd3, 1'b0};
        rows[2] = '{1'b1, 16'h0100, 4'd3, 4'd2, 1'b0};
        rows[3] = '{1'b1, 16'h1ffc, 4'd4, 4'd1, 1'b0};
        rows[4] = '{1'b0, 16'h2000, 4'd5, 4'd2, 1'b0};
        rows[5] = '{1'b1, 16'hf000, 4'd6, 4'd0, 1'b0};
        rows[6] = '{1'b0, 16'h0200, 4'd7, 4'd4, 1'b1};
        rows[7] = '{1'b1, 16'h0300, 4'd8, 4'd3, 1'b0};
        rows[8] = '{1'b0, 16'h1400, 4'd9, 4'd2, 1'b1};
        rows[9] = '{1'b1, 16'h1500, 4'd10, 4'd5, 1'b0};
        fork
            serve_output(0);
            serve_output(1);
            collect_b(0);
            collect_b(1);
        join_none
        repeat (4) begin
            @(negedge clk);
            #3;
            check_idle("valid low in reset");
        end
        @(negedge clk);
        rst = 1'b0;
        #3;
        check_idle("valid low after reset");
        i = 0;
        while (i < N_ROWS) begin
            if (rows[i].conc) begin
                fork
                    run_row(i);
                    run_row(i + 1);
                join
                i = i + 2;
            end else begin
                run_row(i);
                i = i + 1;
            end
        end
        wait_drain();
        // Output 0 holds B, so the third write must stall
        b_hold[0] = 1'b1;
        base = aw_cnt[0];
        fork
            begin
                run_write(0, 16'h0400, 4'd11, 1);
                run_write(0, 16'h0500, 4'd12, 0);
                run_write(0, 16'h0600, 4'd13, 2);
            end
            begin
                repeat (40) @(negedge clk);
                #3;
                check_val("issue limit aw count", 64'(ISSUE), 64'(aw_cnt[0] - base));
                b_hold[0] = 1'b0;
            end
        join
        wait_drain();
        sb_hold[1] = 1'b1;
        run_write(1, 16'h0040, 4'd14, 1);
        run_write(1, 16'h1040, 4'd15, 0);
        repeat (30) @(negedge clk);
        #3;
        check_val("b held valid", 64'(1), 64'(s_b_valid[1]));
        sb_hold[1] = 1'b0;
        wait_drain();
        repeat (4) @(negedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== axi_xbar_wr.f ====
+incdir+sim
design/axi_xbar_pkg.sv
design/rr_arbiter.sv
design/xbar_input_port.sv
design/xbar_output_port.sv
design/axi_xbar_wr.sv
sim/axi_xbar_wr_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the crossbar testbench with Verilator and runs it
cd "$(dirname "$0")" &&
verilator --binary --timing -f axi_xbar_wr.f --top-module axi_xbar_wr_tb \
    -o sim_axi_xbar_wr &&
./obj_dir/sim_axi_xbar_wr || { echo "simulation failed"; exit 1; }
